/* logic/nox_pkg.sv */
`default_nettype none

package nox_pkg;

  typedef logic [31:0] pc_t;
  typedef logic [31:0] instr_raw_t;
  typedef logic [31:0] rdata_t;
  typedef logic [4:0]  raddr_t;
  typedef logic [2:0]  alu_op_t;

  // ALU operation selector
  localparam alu_op_t alu_add    = 3'd0;
  localparam alu_op_t alu_sub    = 3'd1;
  localparam alu_op_t alu_and    = 3'd2;
  localparam alu_op_t alu_or     = 3'd3;
  localparam alu_op_t alu_xor    = 3'd4;
  localparam alu_op_t alu_pass_b = 3'd5;

  // Major opcodes of the supported subset
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;

  // Funct3 codes
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_word = 3'b010;
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // Funct7 codes for register-register ops
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_sub  = 7'b0100000;

endpackage

`default_nettype wire

/* logic/nox_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module nox_ctrl (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       start_fetch_i,
  input  logic       instr_done_i,
  input  logic [6:0] opcode_i,
  input  logic       illegal_i,
  input  logic       branch_taken_i,
  input  logic       lsu_done_i,
  input  logic       lsu_fault_i,
  output logic       fetch_start_o,
  output logic       pc_load_o,
  output logic       pc_sel_jump_o,
  output logic       rf_we_o,
  output logic       lsu_start_o,
  output logic       retire_o,
  output logic       halted_o
);
  typedef enum logic [2:0] {
    st_idle,
    st_fetch,
    st_decode,
    st_execute,
    st_mem,
    st_wb,
    st_halt
  } ctrl_state_t;

  ctrl_state_t state_q;
  logic        fetch_start_q;
  logic        lsu_start_q;
  logic        is_mem_op;
  logic        writes_rd;

  assign is_mem_op = (opcode_i == nox_pkg::opc_load) || (opcode_i == nox_pkg::opc_store);
  assign writes_rd = (opcode_i == nox_pkg::opc_lui) || (opcode_i == nox_pkg::opc_jal) ||
                     (opcode_i == nox_pkg::opc_load) || (opcode_i == nox_pkg::opc_op_imm) ||
                     (opcode_i == nox_pkg::opc_op);

  // Bus strobes are one-cycle pulses on entry to FETCH and MEM
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q       <= st_idle;
      fetch_start_q <= 1'b0;
      lsu_start_q   <= 1'b0;
    end else begin
      fetch_start_q <= 1'b0;
      lsu_start_q   <= 1'b0;
      case (state_q)
        st_idle: begin
          if (start_fetch_i) begin
            state_q       <= st_fetch;
            fetch_start_q <= 1'b1;
          end
        end
        st_fetch: begin
          if (instr_done_i) begin
            state_q <= st_decode;
          end
        end
        st_decode: begin
          state_q <= illegal_i ? st_halt : st_execute;
        end
        st_execute: begin
          if (is_mem_op) begin
            state_q     <= st_mem;
            lsu_start_q <= 1'b1;
          end else begin
            state_q <= st_wb;
          end
        end
        st_mem: begin
          if (lsu_fault_i) begin
            state_q <= st_halt;
          end else if (lsu_done_i) begin
            state_q <= st_wb;
          end
        end
        st_wb: begin
          state_q       <= st_fetch;
          fetch_start_q <= 1'b1;
        end
        default: state_q <= st_halt;
      endcase
    end
  end

  assign fetch_start_o = fetch_start_q;
  assign lsu_start_o   = lsu_start_q;
  assign pc_load_o     = (state_q == st_wb);
  assign pc_sel_jump_o = (opcode_i == nox_pkg::opc_jal) ||
                         ((opcode_i == nox_pkg::opc_branch) && branch_taken_i);
  assign rf_we_o       = (state_q == st_wb) && writes_rd;
  assign retire_o      = (state_q == st_wb);
  assign halted_o      = (state_q == st_halt);

  // Fetch completion only while the machine waits for it
  a_done_in_fetch: assert property (@(posedge clk) disable iff (rst_i)
    instr_done_i |-> (state_q == st_fetch));

  a_lsu_done_in_mem: assert property (@(posedge clk) disable iff (rst_i)
    lsu_done_i |-> (state_q == st_mem));

endmodule

`default_nettype wire

/* logic/nox_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module nox_fetch (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                start_i,
  input  nox_pkg::pc_t        start_addr_i,
  input  logic                fetch_start_i,
  input  logic                pc_load_i,
  input  logic                pc_sel_jump_i,
  input  nox_pkg::pc_t        jump_target_i,
  input  nox_pkg::instr_raw_t instr_rdata_i,
  input  logic                instr_valid_i,
  output logic                instr_req_o,
  output nox_pkg::pc_t        instr_addr_o,
  output nox_pkg::pc_t        pc_o,
  output nox_pkg::instr_raw_t instr_o,
  output logic                instr_done_o
);
  nox_pkg::pc_t        pc_q;
  nox_pkg::instr_raw_t ir_q;
  logic                pending_q;
  logic                misalign_q;
  logic                pc_misaligned;

  assign pc_misaligned = (pc_q[1:0] != 2'b00);

  // A misaligned PC never reaches the bus
  assign instr_req_o  = fetch_start_i && !pc_misaligned;
  assign instr_addr_o = pc_q;
  assign pc_o         = pc_q;
  assign instr_o      = ir_q;
  assign instr_done_o = (pending_q && instr_valid_i) || misalign_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= '0;
    end else if (start_i) begin
      pc_q <= start_addr_i;
    end else if (pc_load_i) begin
      pc_q <= pc_sel_jump_i ? jump_target_i : pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pending_q  <= 1'b0;
      misalign_q <= 1'b0;
    end else begin
      misalign_q <= fetch_start_i && pc_misaligned;
      if (instr_req_o) begin
        pending_q <= 1'b1;
      end else if (instr_valid_i) begin
        pending_q <= 1'b0;
      end
    end
  end

  // All-zero word decodes as illegal and halts the core
  always_ff @(posedge clk) begin
    if (fetch_start_i && pc_misaligned) begin
      ir_q <= '0;
    end else if (pending_q && instr_valid_i) begin
      ir_q <= instr_rdata_i;
    end
  end

  a_no_stray_valid: assert property (@(posedge clk) disable iff (rst_i)
    instr_valid_i |-> pending_q);

endmodule

`default_nettype wire

/* logic/nox_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module nox_decode (
  input  logic                clk,
  input  logic                rst_i,
  input  nox_pkg::instr_raw_t instr_i,
  input  nox_pkg::pc_t        pc_i,
  input  logic                rf_we_i,
  input  nox_pkg::rdata_t     alu_res_i,
  input  nox_pkg::rdata_t     load_data_i,
  output logic [6:0]          opcode_o,
  output logic                illegal_o,
  output nox_pkg::rdata_t     rs1_data_o,
  output nox_pkg::rdata_t     rs2_data_o,
  output nox_pkg::rdata_t     imm_o,
  output nox_pkg::alu_op_t    alu_op_o,
  output logic                use_imm_o
);
  nox_pkg::rdata_t regs [32];
  nox_pkg::raddr_t rd;
  nox_pkg::raddr_t rs1;
  nox_pkg::raddr_t rs2;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  nox_pkg::rdata_t wb_data;

  assign opcode_o = instr_i[6:0];
  assign rd       = instr_i[11:7];
  assign funct3   = instr_i[14:12];
  assign rs1      = instr_i[19:15];
  assign rs2      = instr_i[24:20];
  assign funct7   = instr_i[31:25];

  always_comb begin
    illegal_o = 1'b0;
    alu_op_o  = nox_pkg::alu_add;
    use_imm_o = 1'b1;
    imm_o     = {{20{instr_i[31]}}, instr_i[31:20]};
    case (opcode_o)
      nox_pkg::opc_lui: begin
        alu_op_o = nox_pkg::alu_pass_b;
        imm_o    = {instr_i[31:12], 12'b0};
      end
      nox_pkg::opc_jal: begin
        imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                 instr_i[30:21], 1'b0};
      end
      nox_pkg::opc_branch: begin
        // Execute reads sub as BEQ and xor as BNE
        use_imm_o = 1'b0;
        alu_op_o  = (funct3 == nox_pkg::f3_beq) ? nox_pkg::alu_sub : nox_pkg::alu_xor;
        imm_o     = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
        illegal_o = (funct3 != nox_pkg::f3_beq) && (funct3 != nox_pkg::f3_bne);
      end
      nox_pkg::opc_load: begin
        illegal_o = (funct3 != nox_pkg::f3_word);
      end
      nox_pkg::opc_store: begin
        imm_o     = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        illegal_o = (funct3 != nox_pkg::f3_word);
      end
      nox_pkg::opc_op_imm: begin
        // ADDI only
        illegal_o = (funct3 != nox_pkg::f3_add);
      end
      nox_pkg::opc_op: begin
        use_imm_o = 1'b0;
        case (funct3)
          nox_pkg::f3_add: begin
            alu_op_o  = (funct7 == nox_pkg::f7_sub) ? nox_pkg::alu_sub : nox_pkg::alu_add;
            illegal_o = (funct7 != nox_pkg::f7_base) && (funct7 != nox_pkg::f7_sub);
          end
          nox_pkg::f3_xor: begin
            alu_op_o  = nox_pkg::alu_xor;
            illegal_o = (funct7 != nox_pkg::f7_base);
          end
          nox_pkg::f3_or: begin
            alu_op_o  = nox_pkg::alu_or;
            illegal_o = (funct7 != nox_pkg::f7_base);
          end
          nox_pkg::f3_and: begin
            alu_op_o  = nox_pkg::alu_and;
            illegal_o = (funct7 != nox_pkg::f7_base);
          end
          default: illegal_o = 1'b1;
        endcase
      end
      default: illegal_o = 1'b1;
    endcase
  end

  // Register file, x0 reads as zero
  assign rs1_data_o = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data_o = (rs2 == 5'd0) ? '0 : regs[rs2];

  // Writeback source by instruction class
  always_comb begin
    case (opcode_o)
      nox_pkg::opc_load: wb_data = load_data_i;
      nox_pkg::opc_jal:  wb_data = pc_i + 32'd4;
      default:           wb_data = alu_res_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rf_we_i && !rst_i && (rd != 5'd0)) begin
      regs[rd] <= wb_data;
    end
  end

endmodule

`default_nettype wire

/* logic/nox_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module nox_execute (
  input  logic             clk,
  input  logic             rst_i,
  input  nox_pkg::pc_t     pc_i,
  input  logic [6:0]       opcode_i,
  input  nox_pkg::rdata_t  rs1_data_i,
  input  nox_pkg::rdata_t  rs2_data_i,
  input  nox_pkg::rdata_t  imm_i,
  input  nox_pkg::alu_op_t alu_op_i,
  input  logic             use_imm_i,
  output nox_pkg::rdata_t  alu_res_o,
  output logic             branch_taken_o,
  output nox_pkg::pc_t     jump_target_o
);
  nox_pkg::rdata_t op_b;
  nox_pkg::rdata_t alu_res;
  logic            operands_eq;
  logic            taken;

  assign op_b = use_imm_i ? imm_i : rs2_data_i;

  always_comb begin
    case (alu_op_i)
      nox_pkg::alu_sub:    alu_res = rs1_data_i - op_b;
      nox_pkg::alu_and:    alu_res = rs1_data_i & op_b;
      nox_pkg::alu_or:     alu_res = rs1_data_i | op_b;
      nox_pkg::alu_xor:    alu_res = rs1_data_i ^ op_b;
      nox_pkg::alu_pass_b: alu_res = op_b;
      default:             alu_res = rs1_data_i + op_b;
    endcase
  end

  // BEQ comes in as sub, BNE as xor
  assign operands_eq = (rs1_data_i == rs2_data_i);
  assign taken = (opcode_i == nox_pkg::opc_branch) &&
                 ((alu_op_i == nox_pkg::alu_sub) ? operands_eq : !operands_eq);

  always_ff @(posedge clk) begin
    alu_res_o     <= alu_res;
    jump_target_o <= pc_i + imm_i;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      branch_taken_o <= 1'b0;
    end else begin
      branch_taken_o <= taken;
    end
  end

endmodule

`default_nettype wire

/* logic/nox_lsu.sv */
`timescale 1ns/10ps
`default_nettype none

module nox_lsu #(
  parameter int SUPPORT_WR_RESP = 1
) (
  input  logic            clk,
  input  logic            rst_i,
  input  logic            start_i,
  input  logic            is_store_i,
  input  nox_pkg::rdata_t addr_i,
  input  nox_pkg::rdata_t wdata_i,
  input  nox_pkg::rdata_t data_rdata_i,
  input  logic            data_valid_i,
  output logic            data_req_o,
  output logic            data_we_o,
  output nox_pkg::rdata_t data_addr_o,
  output nox_pkg::rdata_t data_wdata_o,
  output nox_pkg::rdata_t load_data_o,
  output logic            done_o,
  output logic            fault_o
);
  logic pending_q;
  logic store_done_q;
  logic misaligned;
  logic wait_resp;

  assign misaligned = (addr_i[1:0] != 2'b00);
  assign wait_resp  = !is_store_i || (SUPPORT_WR_RESP != 0);

  assign data_req_o   = start_i && !misaligned;
  assign data_we_o    = is_store_i;
  assign data_addr_o  = addr_i;
  assign data_wdata_o = wdata_i;
  assign fault_o      = start_i && misaligned;
  assign done_o       = (pending_q && data_valid_i) || store_done_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pending_q    <= 1'b0;
      store_done_q <= 1'b0;
    end else begin
      // Posted store completes one cycle after its strobe
      store_done_q <= data_req_o && !wait_resp;
      if (data_req_o && wait_resp) begin
        pending_q <= 1'b1;
      end else if (data_valid_i) begin
        pending_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pending_q && data_valid_i && !is_store_i) begin
      load_data_o <= data_rdata_i;
    end
  end

  // No second request while one is still outstanding
  a_req_single: assert property (@(posedge clk) disable iff (rst_i)
    data_req_o |-> !pending_q);

endmodule

`default_nettype wire

/* logic/nox.sv */
`timescale 1ns/10ps
`default_nettype none

module nox #(
  parameter int SUPPORT_WR_RESP = 1
) (
  input  logic                clk,
  input  logic                rst_i,
  // Boot
  input  logic                start_fetch_i,
  input  nox_pkg::pc_t        start_addr_i,
  // Instruction bus
  output logic                instr_req_o,
  output nox_pkg::pc_t        instr_addr_o,
  input  nox_pkg::instr_raw_t instr_rdata_i,
  input  logic                instr_valid_i,
  // Data bus
  output logic                data_req_o,
  output logic                data_we_o,
  output nox_pkg::rdata_t     data_addr_o,
  output nox_pkg::rdata_t     data_wdata_o,
  input  nox_pkg::rdata_t     data_rdata_i,
  input  logic                data_valid_i,
  // Status
  output logic                retire_o,
  output logic                halted_o
);
  logic                fetch_start;
  logic                pc_load;
  logic                pc_sel_jump;
  logic                instr_done;
  logic                rf_we;
  logic                lsu_start;
  logic                lsu_done;
  logic                lsu_fault;
  logic [6:0]          opcode;
  logic                illegal;
  nox_pkg::pc_t        pc;
  nox_pkg::instr_raw_t instr;
  nox_pkg::rdata_t     rs1_data;
  nox_pkg::rdata_t     rs2_data;
  nox_pkg::rdata_t     imm;
  nox_pkg::alu_op_t    alu_op;
  logic                use_imm;
  nox_pkg::rdata_t     alu_res;
  logic                branch_taken;
  nox_pkg::pc_t        jump_target;
  nox_pkg::rdata_t     load_data;

  nox_ctrl u_ctrl (
    .clk            (clk),
    .rst_i          (rst_i),
    .start_fetch_i  (start_fetch_i),
    .instr_done_i   (instr_done),
    .opcode_i       (opcode),
    .illegal_i      (illegal),
    .branch_taken_i (branch_taken),
    .lsu_done_i     (lsu_done),
    .lsu_fault_i    (lsu_fault),
    .fetch_start_o  (fetch_start),
    .pc_load_o      (pc_load),
    .pc_sel_jump_o  (pc_sel_jump),
    .rf_we_o        (rf_we),
    .lsu_start_o    (lsu_start),
    .retire_o       (retire_o),
    .halted_o       (halted_o)
  );

  nox_fetch u_fetch (
    .clk           (clk),
    .rst_i         (rst_i),
    .start_i       (start_fetch_i),
    .start_addr_i  (start_addr_i),
    .fetch_start_i (fetch_start),
    .pc_load_i     (pc_load),
    .pc_sel_jump_i (pc_sel_jump),
    .jump_target_i (jump_target),
    .instr_rdata_i (instr_rdata_i),
    .instr_valid_i (instr_valid_i),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .pc_o          (pc),
    .instr_o       (instr),
    .instr_done_o  (instr_done)
  );

  nox_decode u_decode (
    .clk         (clk),
    .rst_i       (rst_i),
    .instr_i     (instr),
    .pc_i        (pc),
    .rf_we_i     (rf_we),
    .alu_res_i   (alu_res),
    .load_data_i (load_data),
    .opcode_o    (opcode),
    .illegal_o   (illegal),
    .rs1_data_o  (rs1_data),
    .rs2_data_o  (rs2_data),
    .imm_o       (imm),
    .alu_op_o    (alu_op),
    .use_imm_o   (use_imm)
  );

  nox_execute u_execute (
    .clk            (clk),
    .rst_i          (rst_i),
    .pc_i           (pc),
    .opcode_i       (opcode),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .imm_i          (imm),
    .alu_op_i       (alu_op),
    .use_imm_i      (use_imm),
    .alu_res_o      (alu_res),
    .branch_taken_o (branch_taken),
    .jump_target_o  (jump_target)
  );

  // Opcode bit 5 tells SW from LW
  nox_lsu #(
    .SUPPORT_WR_RESP (SUPPORT_WR_RESP)
  ) u_lsu (
    .clk          (clk),
    .rst_i        (rst_i),
    .start_i      (lsu_start),
    .is_store_i   (opcode[5]),
    .addr_i       (alu_res),
    .wdata_i      (rs2_data),
    .data_rdata_i (data_rdata_i),
    .data_valid_i (data_valid_i),
    .data_req_o   (data_req_o),
    .data_we_o    (data_we_o),
    .data_addr_o  (data_addr_o),
    .data_wdata_o (data_wdata_o),
    .load_data_o  (load_data),
    .done_o       (lsu_done),
    .fault_o      (lsu_fault)
  );

endmodule

`default_nettype wire

/* verification/tb_nox.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_nox;

  localparam int mem_words = 256;
  // Opcode 7'h7f is outside the subset and stops the core
  localparam nox_pkg::instr_raw_t stop_word = 32'hffff_ffff;

  logic                clk;
  logic                rst_i;
  logic                start_fetch_i;
  nox_pkg::pc_t        start_addr_i;
  logic                instr_req_o;
  nox_pkg::pc_t        instr_addr_o;
  nox_pkg::instr_raw_t instr_rdata_i;
  logic                instr_valid_i;
  logic                data_req_o;
  logic                data_we_o;
  nox_pkg::rdata_t     data_addr_o;
  nox_pkg::rdata_t     data_wdata_o;
  nox_pkg::rdata_t     data_rdata_i;
  logic                data_valid_i;
  logic                retire_o;
  logic                halted_o;

  nox_pkg::instr_raw_t rom [mem_words];
  nox_pkg::rdata_t     ram [mem_words];
  nox_pkg::instr_raw_t prog_q [$];
  nox_pkg::pc_t        st_addr_q [$];
  nox_pkg::rdata_t     st_data_q [$];

  logic [15:0]  lfsr_q;
  int unsigned  errors;
  int unsigned  checks;
  int           icnt;
  int           dcnt;
  nox_pkg::pc_t iaddr;
  nox_pkg::pc_t daddr;
  nox_pkg::pc_t first_fetch;
  nox_pkg::pc_t last_fetch;
  int unsigned  fetches;
  int unsigned  data_reqs;
  int unsigned  late_fetches;
  int unsigned  retires;
  logic         running;
  int unsigned  run_limit;
  int unsigned  run_cycles;

  nox u_dut (
    .clk           (clk),
    .rst_i         (rst_i),
    .start_fetch_i (start_fetch_i),
    .start_addr_i  (start_addr_i),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_rdata_i (instr_rdata_i),
    .instr_valid_i (instr_valid_i),
    .data_req_o    (data_req_o),
    .data_we_o     (data_we_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_rdata_i  (data_rdata_i),
    .data_valid_i  (data_valid_i),
    .retire_o      (retire_o),
    .halted_o      (halted_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      v      = {v[30:0], lfsr_q[15]};
      lfsr_q = {lfsr_q[14:0], fb};
    end
    return v;
  endfunction

  function automatic nox_pkg::rdata_t ram_fill(input int idx);
    return {~idx[15:0], idx[15:0]};
  endfunction

  function automatic nox_pkg::rdata_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // RV32I instruction formats
  function automatic nox_pkg::instr_raw_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                                 input nox_pkg::raddr_t rd,
                                                 input nox_pkg::raddr_t rs1,
                                                 input nox_pkg::raddr_t rs2);
    return {f7, rs2, rs1, f3, rd, nox_pkg::opc_op};
  endfunction

  function automatic nox_pkg::instr_raw_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                                 input nox_pkg::raddr_t rd,
                                                 input nox_pkg::raddr_t rs1,
                                                 input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic nox_pkg::instr_raw_t s_type(input nox_pkg::raddr_t rs2,
                                                 input nox_pkg::raddr_t rs1,
                                                 input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], nox_pkg::opc_store};
  endfunction

  function automatic nox_pkg::instr_raw_t b_type(input logic [2:0] f3,
                                                 input nox_pkg::raddr_t rs1,
                                                 input nox_pkg::raddr_t rs2,
                                                 input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], nox_pkg::opc_branch};
  endfunction

  function automatic nox_pkg::instr_raw_t u_type(input nox_pkg::raddr_t rd,
                                                 input logic [19:0] imm);
    return {imm, rd, nox_pkg::opc_lui};
  endfunction

  function automatic nox_pkg::instr_raw_t j_type(input nox_pkg::raddr_t rd,
                                                 input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, nox_pkg::opc_jal};
  endfunction

  // Instruction memory with 1 to 4 cycles of latency
  always @(posedge clk) begin
    instr_valid_i <= 1'b0;
    if (rst_i) begin
      icnt         = 0;
      fetches      = 0;
      late_fetches = 0;
    end else begin
      if (instr_req_o) begin
        if (halted_o) begin
          late_fetches++;
        end
        if (fetches == 0) begin
          first_fetch = instr_addr_o;
        end
        last_fetch = instr_addr_o;
        fetches++;
        iaddr = instr_addr_o;
        icnt  = 1 + random_bits(2);
      end
      if (icnt != 0) begin
        icnt = icnt - 1;
        if (icnt == 0) begin
          instr_valid_i <= 1'b1;
          instr_rdata_i <= rom[iaddr[9:2]];
        end
      end
    end
  end

  // Data memory, stores are logged in bus order
  always @(posedge clk) begin
    data_valid_i <= 1'b0;
    if (rst_i) begin
      dcnt      = 0;
      data_reqs = 0;
    end else begin
      if (data_req_o) begin
        data_reqs++;
        daddr = data_addr_o;
        if (data_we_o) begin
          ram[data_addr_o[9:2]] = data_wdata_o;
          st_addr_q.push_back(data_addr_o);
          st_data_q.push_back(data_wdata_o);
        end
        dcnt = 1 + random_bits(2);
      end
      if (dcnt != 0) begin
        dcnt = dcnt - 1;
        if (dcnt == 0) begin
          data_valid_i <= 1'b1;
          data_rdata_i <= ram[daddr[9:2]];
        end
      end
    end
  end

  // Retired instructions since the last reset
  always @(posedge clk) begin
    if (rst_i) begin
      retires = 0;
    end else if (retire_o) begin
      retires++;
    end
  end

  // Bounds each run by its program length
  always @(posedge clk) begin
    if (!running) begin
      run_cycles = 0;
    end else begin
      run_cycles++;
      if (run_cycles > run_limit) begin
        errors++;
        $display("Core did not halt within %0d cycles", run_limit);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
      end
    end
  end

  task automatic check_rdata(input string name, input nox_pkg::rdata_t got,
                             input nox_pkg::rdata_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_pc(input string name, input nox_pkg::pc_t got, input nox_pkg::pc_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int unsigned got,
                             input int unsigned exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic expect_store(input nox_pkg::pc_t addr, input nox_pkg::rdata_t data);
    checks++;
    if (st_addr_q.size() == 0) begin
      errors++;
      $display("Store to 0x%08h never appeared on the data bus", addr);
    end else begin
      check_pc("data_addr_o", st_addr_q.pop_front(), addr);
      check_rdata("data_wdata_o", st_data_q.pop_front(), data);
    end
  endtask

  task automatic expect_bus_quiet();
    checks++;
    if (st_addr_q.size() != 0) begin
      errors++;
      $display("%0d unexpected stores, first one to 0x%08h", st_addr_q.size(), st_addr_q[0]);
    end
  endtask

  // Loads the program at base, resets the core, starts it and waits for the halt
  task automatic run_program(input nox_pkg::pc_t base);
    for (int i = 0; i < mem_words; i++) begin
      rom[i] = {i[24:0], 7'h7f};
      ram[i] = ram_fill(i);
    end
    foreach (prog_q[k]) begin
      rom[int'(base[9:2]) + k] = prog_q[k];
    end
    st_addr_q.delete();
    st_data_q.delete();
    run_limit = 40 * prog_q.size() * 4;
    @(posedge clk);
    rst_i <= 1'b1;
    repeat (8) @(posedge clk);
    rst_i <= 1'b0;
    @(posedge clk);
    check_flag("halted_o", halted_o, 1'b0);
    start_addr_i  <= base;
    start_fetch_i <= 1'b1;
    running       <= 1'b1;
    @(posedge clk);
    start_fetch_i <= 1'b0;
    while (!halted_o) begin
      @(posedge clk);
    end
    running <= 1'b0;
  endtask

  task automatic alu_ops();
    logic [11:0]     a;
    logic [11:0]     b;
    logic [19:0]     u;
    nox_pkg::rdata_t va;
    nox_pkg::rdata_t vb;
    nox_pkg::rdata_t vu;
    a  = random_bits(12);
    b  = random_bits(12);
    u  = random_bits(20);
    va = sext12(a);
    vb = sext12(b);
    vu = {u, 12'h000};
    prog_q.delete();
    prog_q.push_back(i_type(nox_pkg::opc_op_imm, 3'b000, 5'd1, 5'd0, a));
    prog_q.push_back(i_type(nox_pkg::opc_op_imm, 3'b000, 5'd2, 5'd0, b));
    prog_q.push_back(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    prog_q.push_back(r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
    prog_q.push_back(r_type(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
    prog_q.push_back(r_type(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
    prog_q.push_back(r_type(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
    prog_q.push_back(u_type(5'd8, u));
    prog_q.push_back(i_type(nox_pkg::opc_op_imm, 3'b000, 5'd9, 5'd8, a));
    // x3..x9 go to consecutive words from 0x200
    for (int k = 0; k < 7; k++) begin
      prog_q.push_back(s_type(5'(3 + k), 5'd0, 12'(12'h200 + 4 * k)));
    end
    prog_q.push_back(stop_word);
    run_program(32'h0);
    check_count("retire_o", retires, 16);
    expect_store(32'h200, va + vb);
    expect_store(32'h204, va - vb);
    expect_store(32'h208, va & vb);
    expect_store(32'h20c, va | vb);
    expect_store(32'h210, va ^ vb);
    expect_store(32'h214, vu);
    expect_store(32'h218, vu + va);
    expect_bus_quiet();
  endtask

  task automatic reg_zero();
    prog_q.delete();
    prog_q.push_back(i_type(nox_pkg::opc_op_imm, 3'b000, 5'd1, 5'd0, 12'd5));
    prog_q.push_back(i_type(nox_pkg::opc_op_imm, 3'b000, 5'd0, 5'd0, 12'h7ff));
    prog_q.push_back(r_type(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
    prog_q.push_back(s_type(5'd0, 5'd0, 12'h240));
    prog_q.push_back(u_type(5'd0, 20'habcde));
    prog_q.push_back(s_type(5'd0, 5'd0, 12'h244));
    prog_q.push_back(s_type(5'd1, 5'd0, 12'h248));
    prog_q.push_back(stop_word);
    run_program(32'h0);
    check_count("retire_o", retires, 7);
    expect_store(32'h240, 32'h0);
    expect_store(32'h244, 32'h0);
    expect_store(32'h248, 32'd5);
    expect_bus_quiet();
  endtask

  task automatic load_store();
    logic [11:0]     a;
    logic [19:0]     u;
    nox_pkg::rdata_t v;
    a = random_bits(12);
    u = random_bits(20);
    v = {u, 12'h000} + sext12(a);
    prog_q.delete();
    prog_q.push_back(u_type(5'd1, u));
    prog_q.push_back(i_type(nox_pkg::opc_op_imm, 3'b000, 5'd1, 5'd1, a));
    prog_q.push_back(s_type(5'd1, 5'd0, 12'h280));
    prog_q.push_back(i_type(nox_pkg::opc_load, 3'b010, 5'd2, 5'd0, 12'h280));
    prog_q.push_back(i_type(nox_pkg::opc_op_imm, 3'b000, 5'd3, 5'd2, 12'd1));
    prog_q.push_back(s_type(5'd3, 5'd0, 12'h284));
    // Word that only the fill put there
    prog_q.push_back(i_type(nox_pkg::opc_load, 3'b010, 5'd4, 5'd0, 12'h2c0));
    prog_q.push_back(s_type(5'd4, 5'd0, 12'h288));
    prog_q.push_back(stop_word);
    run_program(32'h0);
    check_count("retire_o", retires, 8);
    expect_store(32'h280, v);
    expect_store(32'h284, v + 32'd1);
    expect_store(32'h288, ram_fill(32'h2c0 >> 2));
    expect_bus_quiet();
    check_rdata("ram", ram[32'h280 >> 2], v);
    check_rdata("ram", ram[32'h284 >> 2], v + 32'd1);
  endtask

  task automatic control_flow();
    prog_q.delete();
    prog_q.push_back(i_type(nox_pkg::opc_op_imm, 3'b000, 5'd1, 5'd0, 12'd7));
    prog_q.push_back(i_type(nox_pkg::opc_op_imm, 3'b000, 5'd2, 5'd0, 12'd7));
    prog_q.push_back(b_type(3'b000, 5'd1, 5'd2, 13'd8));
    prog_q.push_back(s_type(5'd1, 5'd0, 12'h300));
    prog_q.push_back(b_type(3'b001, 5'd1, 5'd2, 13'd8));
    prog_q.push_back(s_type(5'd2, 5'd0, 12'h304));
    prog_q.push_back(j_type(5'd5, 21'd8));
    prog_q.push_back(s_type(5'd1, 5'd0, 12'h308));
    prog_q.push_back(s_type(5'd5, 5'd0, 12'h30c));
    prog_q.push_back(stop_word);
    run_program(32'h0);
    check_count("retire_o", retires, 7);
    expect_store(32'h304, 32'd7);
    // Link of the JAL at 0x18
    expect_store(32'h30c, 32'h18 + 32'd4);
    expect_bus_quiet();
  endtask

  task automatic start_address();
    prog_q.delete();
    prog_q.push_back(i_type(nox_pkg::opc_op_imm, 3'b000, 5'd1, 5'd0, 12'h55));
    prog_q.push_back(s_type(5'd1, 5'd0, 12'h310));
    prog_q.push_back(j_type(5'd2, 21'd8));
    prog_q.push_back(s_type(5'd1, 5'd0, 12'h314));
    prog_q.push_back(s_type(5'd2, 5'd0, 12'h318));
    prog_q.push_back(stop_word);
    run_program(32'h80);
    check_count("retire_o", retires, 4);
    check_pc("instr_addr_o", first_fetch, 32'h80);
    expect_store(32'h310, 32'h55);
    expect_store(32'h318, 32'h88 + 32'd4);
    expect_bus_quiet();
  endtask

  task automatic illegal_halt();
    prog_q.delete();
    prog_q.push_back(i_type(nox_pkg::opc_op_imm, 3'b000, 5'd1, 5'd0, 12'd1));
    prog_q.push_back(s_type(5'd1, 5'd0, 12'h320));
    prog_q.push_back(stop_word);
    run_program(32'h40);
    repeat (20) @(posedge clk);
    check_flag("halted_o", halted_o, 1'b1);
    check_count("retire_o", retires, 2);
    check_pc("instr_addr_o", last_fetch, 32'h48);
    checks++;
    if (late_fetches != 0) begin
      errors++;
      $display("Core fetched %0d times after it halted", late_fetches);
    end
    expect_store(32'h320, 32'd1);
    expect_bus_quiet();
  endtask

  task automatic misaligned_halt();
    prog_q.delete();
    prog_q.push_back(i_type(nox_pkg::opc_op_imm, 3'b000, 5'd1, 5'd0, 12'd2));
    prog_q.push_back(i_type(nox_pkg::opc_load, 3'b010, 5'd2, 5'd1, 12'h200));
    prog_q.push_back(s_type(5'd1, 5'd0, 12'h330));
    prog_q.push_back(stop_word);
    run_program(32'h0);
    repeat (20) @(posedge clk);
    check_flag("halted_o", halted_o, 1'b1);
    check_count("retire_o", retires, 1);
    check_pc("instr_addr_o", last_fetch, 32'h4);
    checks++;
    if (data_reqs != 0) begin
      errors++;
      $display("Misaligned load still made %0d data bus requests", data_reqs);
    end
    expect_bus_quiet();
  endtask

  initial begin
    lfsr_q        = 16'd28;
    errors        = 0;
    checks        = 0;
    running       = 1'b0;
    run_limit     = 0;
    rst_i         = 1'b1;
    start_fetch_i = 1'b0;
    start_addr_i  = '0;
    instr_rdata_i = '0;
    instr_valid_i = 1'b0;
    data_rdata_i  = '0;
    data_valid_i  = 1'b0;
    alu_ops();
    reg_zero();
    load_store();
    control_flow();
    start_address();
    illegal_halt();
    misaligned_halt();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
logic/nox_pkg.sv
logic/nox_ctrl.sv
logic/nox_fetch.sv
logic/nox_decode.sv
logic/nox_execute.sv
logic/nox_lsu.sv
logic/nox.sv
verification/tb_nox.sv

/* Bender.yml */
package:
  name: nox

sources:
  - logic/nox_pkg.sv
  - logic/nox_ctrl.sv
  - logic/nox_fetch.sv
  - logic/nox_decode.sv
  - logic/nox_execute.sv
  - logic/nox_lsu.sv
  - logic/nox.sv
  - target: test
    files:
      - verification/tb_nox.sv
